// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_mshr
FILELIST = src.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: sim/tb_mshr.sv
`timescale 1ns/100ps

module tb_mshr;

  localparam int DEPTH   = 8;
  localparam int TIMEOUT = 400;

  logic                  clock;
  logic                  reset;
  logic                  load_req;
  mshr_pkg::addr_t       load_addr;
  logic                  load_ack;
  logic                  wb_req;
  mshr_pkg::addr_t       wb_addr;
  mshr_pkg::data_t       wb_data;
  logic                  wb_ack;
  mem_bus_pkg::mem_cmd_t mem_command;
  mshr_pkg::addr_t       mem_addr;
  mshr_pkg::data_t       mem_data;
  mem_bus_pkg::mem_tag_t mem_response = '0;
  mem_bus_pkg::mem_tag_t mem_tag = '0;
  mshr_pkg::data_t       mem_data_in = '0;
  logic                  fill_valid;
  mshr_pkg::addr_t       fill_addr;
  mshr_pkg::data_t       fill_data;
  logic                  fill_taken = 1'b0;

  logic [15:0] lfsr = 16'd45;
  logic mem_hold;
  logic cache_hold;
  int check_errors = 0;
  int timeout_errors = 0;
  mshr_pkg::addr_t load_q [$];
  mshr_pkg::addr_t store_addr_q [$];
  mshr_pkg::data_t store_data_q [$];

  mshr_top #(.DEPTH(DEPTH)) i_mshr_top (.*);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] v;
    logic fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v = {v[62:0], fb};
    end
    return v;
  endfunction

  function automatic mshr_pkg::addr_t rnd_addr();
    return take_bits(58) << 6;
  endfunction

  function automatic mshr_pkg::data_t expected_fill_data(input mshr_pkg::addr_t addr);
    return addr ^ 64'hA5A5_0000_5A5A_FFFF;
  endfunction

  function automatic logic is_pending_load(input mshr_pkg::addr_t addr);
    for (int i = 0; i < load_q.size(); i++) begin
      if (load_q[i] == addr) return 1'b1;
    end
    return 1'b0;
  endfunction

  task automatic report(input string msg);
    check_errors++;
    $display("ERROR: %s", msg);
  endtask

  task automatic timed_out(input string what);
    timeout_errors++;
    $display("TIMEOUT: gave up waiting for %s", what);
  endtask

  task automatic check_fill(input mshr_pkg::addr_t exp_addr, input mshr_pkg::data_t exp_data);
    if (fill_addr !== exp_addr) begin
      check_errors++;
      $display("CHECK FAILED fill_addr: got %h expected %h", fill_addr, exp_addr);
    end
    if (fill_data !== exp_data) begin
      check_errors++;
      $display("CHECK FAILED fill_data: got %h expected %h", fill_data, exp_data);
    end
  endtask

  task automatic check_store(input mshr_pkg::addr_t exp_addr, input mshr_pkg::data_t exp_data);
    if (mem_addr !== exp_addr) begin
      check_errors++;
      $display("CHECK FAILED mem_addr: got %h expected %h", mem_addr, exp_addr);
    end
    if (mem_data !== exp_data) begin
      check_errors++;
      $display("CHECK FAILED mem_data: got %h expected %h", mem_data, exp_data);
    end
  endtask

  task automatic check_command(input mem_bus_pkg::mem_cmd_t exp_cmd);
    if (mem_command !== exp_cmd) begin
      check_errors++;
      $display("CHECK FAILED mem_command: got %h expected %h", mem_command, exp_cmd);
    end
  endtask

  // memory model takes one offer at a time and returns loads after a random delay
  logic [15:1] busy;
  int ret_wait [16];
  mshr_pkg::addr_t tag_addr [16];
  int offer_wait;

  always @(posedge clock) begin : memory_model
    int ret;
    int free;
    mem_bus_pkg::mem_cmd_t exp_cmd;
    if (reset) begin
      mem_response <= '0;
      mem_tag <= '0;
      busy = '0;
      offer_wait = 0;
    end else begin
      free = 0;
      for (int t = 15; t >= 1; t--) begin
        if (!busy[t]) free = t;
      end
      if (mem_response != '0) begin
        // the DUT takes the head at this edge
        if (is_pending_load(mem_addr)) begin
          exp_cmd = mem_bus_pkg::BUS_LOAD;
        end else begin
          exp_cmd = mem_bus_pkg::BUS_STORE;
        end
        check_command(exp_cmd);
        if (exp_cmd == mem_bus_pkg::BUS_LOAD) begin
          busy[mem_response] = 1'b1;
          tag_addr[mem_response] = mem_addr;
          ret_wait[mem_response] = int'(take_bits(4));
        end else if (store_addr_q.size() == 0) begin
          report("store reached memory with no eviction outstanding");
        end else begin
          check_store(store_addr_q.pop_front(), store_data_q.pop_front());
        end
        mem_response <= '0;
      end else if (mem_command != mem_bus_pkg::BUS_NONE && !mem_hold && free != 0) begin
        if (offer_wait > 0) begin
          offer_wait = offer_wait - 1;
        end else begin
          mem_response <= free[3:0];
          offer_wait = int'(take_bits(2));
        end
      end
      ret = 0;
      for (int t = 1; t <= 15; t++) begin
        if (busy[t] && ret_wait[t] > 0) ret_wait[t] = ret_wait[t] - 1;
        else if (busy[t] && ret == 0) ret = t;
      end
      if (ret != 0) begin
        busy[ret] = 1'b0;
        mem_tag <= ret[3:0];
        mem_data_in <= expected_fill_data(tag_addr[ret]);
      end else begin
        mem_tag <= '0;
      end
    end
  end

  always @(posedge clock) begin : cache_model
    logic [63:0] r;
    r = take_bits(1);
    fill_taken <= !reset && !cache_hold && r[0];
  end

  logic held = 1'b0;
  mshr_pkg::addr_t held_addr;
  mshr_pkg::data_t held_data;

  always @(posedge clock) begin : fill_checker
    mshr_pkg::addr_t exp_addr;
    if (!reset && fill_valid) begin
      // a waiting fill must not move
      if (held) check_fill(held_addr, held_data);
      if (!fill_taken) begin
        held = 1'b1;
        held_addr = fill_addr;
        held_data = fill_data;
      end else if (load_q.size() == 0) begin
        report("fill with no load outstanding");
        held = 1'b0;
      end else begin
        exp_addr = load_q.pop_front();
        check_fill(exp_addr, expected_fill_data(exp_addr));
        held = 1'b0;
      end
    end else begin
      if (held) report("fill dropped before the cache took it");
      held = 1'b0;
    end
  end

  function automatic logic ack_of(input logic is_wb);
    return is_wb ? wb_ack : load_ack;
  endfunction

  task automatic request(input logic is_wb, input mshr_pkg::addr_t addr,
                         input mshr_pkg::data_t data);
    int n;
    @(posedge clock);
    if (is_wb) begin
      store_addr_q.push_back(addr);
      store_data_q.push_back(data);
      wb_addr <= addr;
      wb_data <= data;
      wb_req <= 1'b1;
    end else begin
      load_q.push_back(addr);
      load_addr <= addr;
      load_req <= 1'b1;
    end
    n = 0;
    while (ack_of(is_wb) !== 1'b1 && n < TIMEOUT) begin
      @(posedge clock);
      n++;
    end
    if (ack_of(is_wb) !== 1'b1) timed_out("ack to rise");
    if (is_wb) begin
      wb_req <= 1'b0;
    end else begin
      load_req <= 1'b0;
    end
    n = 0;
    while (ack_of(is_wb) !== 1'b0 && n < TIMEOUT) begin
      @(posedge clock);
      n++;
    end
    if (ack_of(is_wb) !== 1'b0) timed_out("ack to fall");
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while (load_q.size() + store_addr_q.size() != 0 && n < TIMEOUT) begin
      @(posedge clock);
      n++;
    end
    if (load_q.size() + store_addr_q.size() != 0) timed_out("outstanding requests");
  endtask

  task automatic wait_fill();
    int n;
    n = 0;
    while (fill_valid !== 1'b1 && n < TIMEOUT) begin
      @(posedge clock);
      n++;
    end
    if (fill_valid !== 1'b1) timed_out("fill_valid");
  endtask

  initial begin
    reset = 1'b1;
    load_req = 1'b0;
    load_addr = '0;
    wb_req = 1'b0;
    wb_addr = '0;
    wb_data = '0;
    mem_hold = 1'b0;
    cache_hold = 1'b0;
    repeat (8) @(posedge clock);
    reset <= 1'b0;

    request(1'b0, rnd_addr(), '0);
    wait_drained();
    request(1'b1, rnd_addr(), take_bits(64));
    wait_drained();

    // several loads in flight, returns out of order
    for (int i = 0; i < 6; i++) request(1'b0, rnd_addr(), '0);
    wait_drained();

    fork
      request(1'b0, rnd_addr(), '0);
      request(1'b1, rnd_addr(), take_bits(64));
    join
    wait_drained();

    // stalled memory and cache fill the queue
    mem_hold <= 1'b1;
    cache_hold <= 1'b1;
    for (int i = 0; i < DEPTH; i++) request(i[0], rnd_addr(), take_bits(64));
    fork
      request(1'b0, rnd_addr(), '0);
      begin
        for (int i = 0; i < 20; i++) begin
          @(posedge clock);
          if (load_ack) report("ack rose while the queue was full");
        end
        mem_hold <= 1'b0;
        cache_hold <= 1'b0;
      end
    join
    wait_drained();

    // fill waits on the cache
    cache_hold <= 1'b1;
    request(1'b0, rnd_addr(), '0);
    wait_fill();
    repeat (6) @(posedge clock);
    if (fill_valid !== 1'b1) report("fill retired without fill_taken");
    cache_hold <= 1'b0;
    wait_drained();

    $display("errors: %0d check, %0d timeout", check_errors, timeout_errors);
    if (check_errors == 0 && timeout_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: src.f
verilog/mem_bus_pkg.sv
verilog/mshr_pkg.sv
verilog/miss_req_port.sv
verilog/alloc_arbiter.sv
verilog/miss_queue.sv
verilog/mshr_top.sv
sim/tb_mshr.sv

// File: verilog/alloc_arbiter.sv
`timescale 1ns/100ps

module alloc_arbiter #(
  parameter int DEPTH = 8
) (
  input  logic                clock,
  input  logic                reset,
  input  logic                load_pending,
  input  mshr_pkg::load_req_t load_payload,
  input  logic                wb_pending,
  input  mshr_pkg::wb_req_t   wb_payload,
  input  logic                full,
  output logic                load_grant,
  output logic                wb_grant,
  output logic                alloc_valid,
  output logic                alloc_is_store,
  output mshr_pkg::addr_t     alloc_addr,
  output mshr_pkg::data_t     alloc_data
);

  // queue pointers wrap by overflow
  if (DEPTH < 2 || (DEPTH & (DEPTH - 1)) != 0) begin : g_depth_check
    $error("alloc_arbiter: DEPTH must be a power of two, got %0d", DEPTH);
  end

  logic last_wb;

  // the port that lost last time goes first on a tie
  assign load_grant = load_pending && !full && (!wb_pending || last_wb);
  assign wb_grant   = wb_pending && !full && (!load_pending || !last_wb);

  always_ff @(posedge clock) begin
    if (reset) begin
      last_wb <= 1'b0;
    end else if (load_grant) begin
      last_wb <= 1'b0;
    end else if (wb_grant) begin
      last_wb <= 1'b1;
    end
  end

  assign alloc_valid    = load_grant || wb_grant;
  assign alloc_is_store = wb_grant;
  assign alloc_addr     = wb_grant ? wb_payload.addr : load_payload;
  // loads carry no data until memory returns it
  assign alloc_data     = wb_grant ? wb_payload.data : '0;

endmodule

// File: verilog/mem_bus_pkg.sv
package mem_bus_pkg;

  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2
  } mem_cmd_t;

  // zero means no transaction
  typedef logic [3:0] mem_tag_t;

endpackage

// File: verilog/miss_queue.sv
`timescale 1ns/100ps

module miss_queue #(
  parameter int DEPTH = 8
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  alloc_valid,
  input  logic                  alloc_is_store,
  input  mshr_pkg::addr_t       alloc_addr,
  input  mshr_pkg::data_t       alloc_data,
  input  mem_bus_pkg::mem_tag_t mem_response,
  input  mem_bus_pkg::mem_tag_t mem_tag,
  input  mshr_pkg::data_t       mem_data_in,
  input  logic                  fill_taken,
  output logic                  full,
  output mem_bus_pkg::mem_cmd_t mem_command,
  output mshr_pkg::addr_t       mem_addr,
  output mshr_pkg::data_t       mem_data,
  output logic                  fill_valid,
  output mshr_pkg::addr_t       fill_addr,
  output mshr_pkg::data_t       fill_data
);

  localparam int PTR_W = $clog2(DEPTH);

  mshr_pkg::entry_t entries [DEPTH];

  logic [PTR_W-1:0] tail;
  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] retire;

  mshr_pkg::entry_t head_entry;
  mshr_pkg::entry_t retire_entry;

  logic issue_ok;
  logic retire_fire;
  logic [DEPTH-1:0] tag_hit;

  assign head_entry   = entries[head];
  assign retire_entry = entries[retire];

  // tail slot still busy means no room
  assign full = entries[tail].valid;

  always_comb begin
    mem_command = mem_bus_pkg::BUS_NONE;
    if (head_entry.valid && head_entry.state == mshr_pkg::WAITING) begin
      if (head_entry.is_store) begin
        mem_command = mem_bus_pkg::BUS_STORE;
      end else begin
        mem_command = mem_bus_pkg::BUS_LOAD;
      end
    end
  end

  assign mem_addr = head_entry.addr;
  assign mem_data = head_entry.data;

  // non-zero response is the accept
  assign issue_ok = (mem_command != mem_bus_pkg::BUS_NONE) && (mem_response != '0);

  // returned tag matched against every in-flight load
  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      tag_hit[i] = entries[i].valid && !entries[i].is_store &&
                   entries[i].state == mshr_pkg::INPROGRESS &&
                   mem_tag != '0 && entries[i].mem_tag == mem_tag;
    end
  end

  assign fill_valid = retire_entry.valid && !retire_entry.is_store &&
                      retire_entry.state == mshr_pkg::DONE;
  assign fill_addr  = retire_entry.addr;
  assign fill_data  = retire_entry.data;

  // stores leave without a fill
  assign retire_fire = retire_entry.valid && retire_entry.state == mshr_pkg::DONE &&
                       (retire_entry.is_store || fill_taken);

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < DEPTH; i++) begin
        entries[i].valid <= 1'b0;
      end
      tail   <= '0;
      head   <= '0;
      retire <= '0;
    end else begin
      if (retire_fire) begin
        entries[retire].valid <= 1'b0;
        retire <= retire + 1'b1;
      end

      if (issue_ok) begin
        entries[head].mem_tag <= mem_response;
        if (head_entry.is_store) begin
          entries[head].state <= mshr_pkg::DONE;
        end else begin
          entries[head].state <= mshr_pkg::INPROGRESS;
        end
        head <= head + 1'b1;
      end

      for (int i = 0; i < DEPTH; i++) begin
        if (tag_hit[i]) begin
          entries[i].state <= mshr_pkg::DONE;
          entries[i].data  <= mem_data_in;
        end
      end

      // arbiter never grants into a busy slot
      if (alloc_valid) begin
        entries[tail].valid    <= 1'b1;
        entries[tail].is_store <= alloc_is_store;
        entries[tail].state    <= mshr_pkg::WAITING;
        entries[tail].mem_tag  <= '0;
        entries[tail].addr     <= alloc_addr;
        entries[tail].data     <= alloc_data;
        tail <= tail + 1'b1;
      end
    end
  end

endmodule

// File: verilog/miss_req_port.sv
`timescale 1ns/100ps

module miss_req_port #(
  parameter type payload_t = logic
) (
  input  logic     clock,
  input  logic     reset,
  input  logic     req,
  input  payload_t req_payload,
  input  logic     grant,
  output logic     ack,
  output logic     pending,
  output payload_t payload
);

  typedef enum logic [1:0] {
    IDLE  = 2'h0,
    HOLD  = 2'h1,
    ACKED = 2'h2
  } phase_t;

  phase_t phase;
  phase_t next_phase;

  always_comb begin
    next_phase = phase;
    case (phase)
      IDLE: begin
        if (req) begin
          next_phase = HOLD;
        end
      end
      HOLD: begin
        if (grant) begin
          next_phase = ACKED;
        end
      end
      ACKED: begin
        // wait for the requester to let go
        if (!req) begin
          next_phase = IDLE;
        end
      end
      default: next_phase = IDLE;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      phase <= IDLE;
    end else begin
      phase <= next_phase;
    end
  end

  // captured once, stays put while arbitrated
  always_ff @(posedge clock) begin
    if (phase == IDLE && req) begin
      payload <= req_payload;
    end
  end

  assign pending = (phase == HOLD);
  assign ack     = (phase == ACKED);

endmodule

// File: verilog/mshr_pkg.sv
package mshr_pkg;

  typedef logic [63:0] addr_t;
  typedef logic [63:0] data_t;

  // a load miss only needs the line address
  typedef addr_t load_req_t;

  // dirty line on its way out
  typedef struct packed {
    addr_t addr;
    data_t data;
  } wb_req_t;

  typedef enum logic [1:0] {
    WAITING    = 2'h0,
    INPROGRESS = 2'h1,
    DONE       = 2'h2
  } entry_state_t;

  typedef struct packed {
    logic                 valid;
    logic                 is_store;
    entry_state_t         state;
    mem_bus_pkg::mem_tag_t mem_tag;
    addr_t                addr;
    data_t                data;
  } entry_t;

endpackage

// File: verilog/mshr_top.sv
`timescale 1ns/100ps

module mshr_top #(
  parameter int DEPTH = 8
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  load_req,
  input  mshr_pkg::addr_t       load_addr,
  output logic                  load_ack,
  input  logic                  wb_req,
  input  mshr_pkg::addr_t       wb_addr,
  input  mshr_pkg::data_t       wb_data,
  output logic                  wb_ack,
  output mem_bus_pkg::mem_cmd_t mem_command,
  output mshr_pkg::addr_t       mem_addr,
  output mshr_pkg::data_t       mem_data,
  input  mem_bus_pkg::mem_tag_t mem_response,
  input  mem_bus_pkg::mem_tag_t mem_tag,
  input  mshr_pkg::data_t       mem_data_in,
  output logic                  fill_valid,
  output mshr_pkg::addr_t       fill_addr,
  output mshr_pkg::data_t       fill_data,
  input  logic                  fill_taken
);

  mshr_pkg::wb_req_t   wb_in;
  mshr_pkg::load_req_t load_payload;
  mshr_pkg::wb_req_t   wb_payload;
  logic                load_pending;
  logic                wb_pending;
  logic                load_grant;
  logic                wb_grant;
  logic                alloc_valid;
  logic                alloc_is_store;
  mshr_pkg::addr_t     alloc_addr;
  mshr_pkg::data_t     alloc_data;
  logic                full;

  assign wb_in = '{addr: wb_addr, data: wb_data};

  miss_req_port #(.payload_t(mshr_pkg::load_req_t)) i_load_port (
    .clock(clock), .reset(reset), .req(load_req), .req_payload(load_addr),
    .grant(load_grant), .ack(load_ack), .pending(load_pending), .payload(load_payload)
  );

  miss_req_port #(.payload_t(mshr_pkg::wb_req_t)) i_wb_port (
    .clock(clock), .reset(reset), .req(wb_req), .req_payload(wb_in),
    .grant(wb_grant), .ack(wb_ack), .pending(wb_pending), .payload(wb_payload)
  );

  alloc_arbiter #(.DEPTH(DEPTH)) i_arbiter (
    .clock(clock), .reset(reset),
    .load_pending(load_pending), .load_payload(load_payload),
    .wb_pending(wb_pending), .wb_payload(wb_payload), .full(full),
    .load_grant(load_grant), .wb_grant(wb_grant),
    .alloc_valid(alloc_valid), .alloc_is_store(alloc_is_store),
    .alloc_addr(alloc_addr), .alloc_data(alloc_data)
  );

  miss_queue #(.DEPTH(DEPTH)) i_queue (
    .clock(clock), .reset(reset),
    .alloc_valid(alloc_valid), .alloc_is_store(alloc_is_store),
    .alloc_addr(alloc_addr), .alloc_data(alloc_data),
    .mem_response(mem_response), .mem_tag(mem_tag), .mem_data_in(mem_data_in),
    .fill_taken(fill_taken), .full(full),
    .mem_command(mem_command), .mem_addr(mem_addr), .mem_data(mem_data),
    .fill_valid(fill_valid), .fill_addr(fill_addr), .fill_data(fill_data)
  );

endmodule
